// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mesh
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: design/link_fifo.sv
`timescale 1ns/100ps

module link_fifo
  import noc_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    in_valid_i,
  input  packet_t in_packet_i,
  output logic    in_ready_o,
  output logic    out_valid_o,
  output packet_t out_packet_o,
  input  logic    out_ready_i
);

  packet_t    mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  // Ready from occupancy only
  assign in_ready_o   = (count_r != 2'd2);
  assign out_valid_o  = (count_r != 2'd0);
  assign out_packet_o = mem_r[rd_ptr_r];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      count_r <= count_r + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= in_packet_i;
    end
  end

  // Occupancy stays within two entries, no wrap on over- or underflow
  assert property (@(posedge clk_i) disable iff (reset_i) count_r <= 2'd2);

endmodule

// File: design/mesh_router.sv
`timescale 1ns/100ps

module mesh_router
  import noc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  coord_t                     my_x_i,
  input  coord_t                     my_y_i,
  input  logic    [num_ports_lp-1:0] in_valid_i,
  input  packet_t [num_ports_lp-1:0] in_packet_i,
  output logic    [num_ports_lp-1:0] in_ready_o,
  output logic    [num_ports_lp-1:0] out_valid_o,
  output packet_t [num_ports_lp-1:0] out_packet_o,
  input  logic    [num_ports_lp-1:0] out_ready_i
);

  logic    [num_ports_lp-1:0]                   head_valid;
  packet_t [num_ports_lp-1:0]                   head_packet;
  coord_t  [num_ports_lp-1:0]                   head_x;
  coord_t  [num_ports_lp-1:0]                   head_y;
  logic    [num_ports_lp-1:0]                   pop;
  logic    [num_ports_lp-1:0][num_ports_lp-1:0] grant;
  logic    [num_ports_lp-1:0]                   out_free;
  packet_t [num_ports_lp-1:0]                   xbar;
  logic    [num_ports_lp-1:0]                   out_valid_r;
  packet_t [num_ports_lp-1:0]                   out_packet_r;

  for (genvar i = 0; i < num_ports_lp; i++) begin : g_in
    link_fifo fifo (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_valid_i  (in_valid_i[i]),
      .in_packet_i (in_packet_i[i]),
      .in_ready_o  (in_ready_o[i]),
      .out_valid_o (head_valid[i]),
      .out_packet_o(head_packet[i]),
      .out_ready_i (pop[i])
    );

    assign head_x[i] = pkt_x(head_packet[i]);
    assign head_y[i] = pkt_y(head_packet[i]);
  end

  // Output slot is free if empty or draining now
  assign out_free = ~out_valid_r | out_ready_i;

  route_ctrl ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .head_valid_i(head_valid),
    .head_x_i    (head_x),
    .head_y_i    (head_y),
    .out_free_i  (out_free),
    .grant_o     (grant),
    .pop_o       (pop)
  );

  // Crossbar, grants are one-hot per output
  always_comb begin
    xbar = '0;
    for (int o = 0; o < num_ports_lp; o++) begin
      for (int i = 0; i < num_ports_lp; i++) begin
        if (grant[o][i]) begin
          xbar[o] = head_packet[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_r <= '0;
    end else begin
      for (int o = 0; o < num_ports_lp; o++) begin
        if (|grant[o]) begin
          out_valid_r[o] <= 1'b1;
        end else if (out_ready_i[o]) begin
          out_valid_r[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < num_ports_lp; o++) begin
      if (|grant[o]) begin
        out_packet_r[o] <= xbar[o];
      end
    end
  end

  assign out_valid_o  = out_valid_r;
  assign out_packet_o = out_packet_r;

  // A stalled output holds its packet
  for (genvar o = 0; o < num_ports_lp; o++) begin : g_hold
    assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid_o[o] && !out_ready_i[o] |=> out_valid_o[o] && $stable(out_packet_o[o]));
  end

endmodule

// File: design/mesh_top.sv
`timescale 1ns/100ps

module mesh_top
  import noc_pkg::*;
  import tile_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         start_i,
  input  round_t                       rounds_i,
  input  logic      [num_nodes_lp-1:0] stall_i,
  output logic                         done_o,
  output checksum_t [num_nodes_lp-1:0] checksum_o,
  output logic                         misroute_o
);

  // Router-side view of every link, [node][port]
  logic    [num_ports_lp-1:0] in_valid   [num_nodes_lp];
  packet_t [num_ports_lp-1:0] in_packet  [num_nodes_lp];
  logic    [num_ports_lp-1:0] in_ready   [num_nodes_lp];
  logic    [num_ports_lp-1:0] out_valid  [num_nodes_lp];
  packet_t [num_ports_lp-1:0] out_packet [num_nodes_lp];
  logic    [num_ports_lp-1:0] out_ready  [num_nodes_lp];

  logic [num_nodes_lp-1:0] tile_done;
  logic [num_nodes_lp-1:0] tile_misroute;

  for (genvar n = 0; n < num_nodes_lp; n++) begin : g_node
    localparam int x_lp = n % mesh_x_lp;
    localparam int y_lp = n / mesh_x_lp;

    if (x_lp > 0) begin : g_w
      assign in_valid[n][W]  = out_valid[n-1][E];
      assign in_packet[n][W] = out_packet[n-1][E];
      assign out_ready[n][W] = in_ready[n-1][E];
    end else begin : g_w_edge
      assign in_valid[n][W]  = 1'b0;
      assign in_packet[n][W] = '0;
      assign out_ready[n][W] = 1'b1;
    end

    if (x_lp < mesh_x_lp - 1) begin : g_e
      assign in_valid[n][E]  = out_valid[n+1][W];
      assign in_packet[n][E] = out_packet[n+1][W];
      assign out_ready[n][E] = in_ready[n+1][W];
    end else begin : g_e_edge
      assign in_valid[n][E]  = 1'b0;
      assign in_packet[n][E] = '0;
      assign out_ready[n][E] = 1'b1;
    end

    if (y_lp > 0) begin : g_n
      assign in_valid[n][N]  = out_valid[n-mesh_x_lp][S];
      assign in_packet[n][N] = out_packet[n-mesh_x_lp][S];
      assign out_ready[n][N] = in_ready[n-mesh_x_lp][S];
    end else begin : g_n_edge
      assign in_valid[n][N]  = 1'b0;
      assign in_packet[n][N] = '0;
      assign out_ready[n][N] = 1'b1;
    end

    if (y_lp < mesh_y_lp - 1) begin : g_s
      assign in_valid[n][S]  = out_valid[n+mesh_x_lp][N];
      assign in_packet[n][S] = out_packet[n+mesh_x_lp][N];
      assign out_ready[n][S] = in_ready[n+mesh_x_lp][N];
    end else begin : g_s_edge
      assign in_valid[n][S]  = 1'b0;
      assign in_packet[n][S] = '0;
      assign out_ready[n][S] = 1'b1;
    end

    mesh_router router (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .my_x_i      (coord_t'(x_lp)),
      .my_y_i      (coord_t'(y_lp)),
      .in_valid_i  (in_valid[n]),
      .in_packet_i (in_packet[n]),
      .in_ready_o  (in_ready[n]),
      .out_valid_o (out_valid[n]),
      .out_packet_o(out_packet[n]),
      .out_ready_i (out_ready[n])
    );

    // Tile sits on the local port
    traffic_tile tile (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .my_x_i      (coord_t'(x_lp)),
      .my_y_i      (coord_t'(y_lp)),
      .start_i     (start_i),
      .rounds_i    (rounds_i),
      .stall_i     (stall_i[n]),
      .inj_valid_o (in_valid[n][P]),
      .inj_packet_o(in_packet[n][P]),
      .inj_ready_i (in_ready[n][P]),
      .ej_valid_i  (out_valid[n][P]),
      .ej_packet_i (out_packet[n][P]),
      .ej_ready_o  (out_ready[n][P]),
      .checksum_o  (checksum_o[n]),
      .done_o      (tile_done[n]),
      .misroute_o  (tile_misroute[n])
    );
  end

  assign done_o     = &tile_done;
  assign misroute_o = |tile_misroute;

endmodule

// File: design/noc_pkg.sv
package noc_pkg;

  // Mesh size
  localparam int mesh_x_lp    = 2;
  localparam int mesh_y_lp    = 2;
  localparam int num_nodes_lp = mesh_x_lp * mesh_y_lp;

  // Local port plus four neighbours
  localparam int num_ports_lp = 5;

  typedef logic [0:0] coord_t;
  typedef logic [1:0] node_id_t;

  // Upper nibble round, lower nibble source id
  typedef logic [7:0] payload_t;

  // Packet layout {x, y, payload}
  localparam int packet_width_lp = 2 * $bits(coord_t) + $bits(payload_t);
  typedef logic [packet_width_lp-1:0] packet_t;

  // Port order doubles as the port index
  typedef enum logic [2:0] {P, W, E, N, S} dir_e;

  function automatic coord_t pkt_x(packet_t pkt);
    return pkt[packet_width_lp-1];
  endfunction

  function automatic coord_t pkt_y(packet_t pkt);
    return pkt[packet_width_lp-2];
  endfunction

  function automatic payload_t pkt_payload(packet_t pkt);
    return pkt[$bits(payload_t)-1:0];
  endfunction

  function automatic packet_t pkt_make(coord_t x, coord_t y, payload_t payload);
    return {x, y, payload};
  endfunction

endpackage

// File: design/route_ctrl.sv
`timescale 1ns/100ps

module route_ctrl
  import noc_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  coord_t                                    my_x_i,
  input  coord_t                                    my_y_i,
  input  logic   [num_ports_lp-1:0]                 head_valid_i,
  input  coord_t [num_ports_lp-1:0]                 head_x_i,
  input  coord_t [num_ports_lp-1:0]                 head_y_i,
  input  logic   [num_ports_lp-1:0]                 out_free_i,
  output logic   [num_ports_lp-1:0][num_ports_lp-1:0] grant_o,
  output logic   [num_ports_lp-1:0]                 pop_o
);

  // Requests and grants indexed [output][input]
  logic [num_ports_lp-1:0][num_ports_lp-1:0] req;
  // Same grants indexed [input][output]
  logic [num_ports_lp-1:0][num_ports_lp-1:0] grant_by_in;
  logic [2:0] ptr_r [num_ports_lp];

  // X first, then Y; y grows towards S
  always_comb begin
    dir_e want;
    req = '0;
    for (int i = 0; i < num_ports_lp; i++) begin
      if (head_x_i[i] != my_x_i) begin
        want = (head_x_i[i] > my_x_i) ? E : W;
      end else if (head_y_i[i] != my_y_i) begin
        want = (head_y_i[i] > my_y_i) ? S : N;
      end else begin
        want = P;
      end
      req[want][i] = head_valid_i[i];
    end
  end

  // One round-robin arbiter per output, lowest offset from the pointer wins
  always_comb begin
    int idx;
    grant_o = '0;
    for (int o = 0; o < num_ports_lp; o++) begin
      for (int k = num_ports_lp - 1; k >= 0; k--) begin
        idx = int'(ptr_r[o]) + k;
        if (idx >= num_ports_lp) begin
          idx = idx - num_ports_lp;
        end
        if (req[o][idx] && out_free_i[o]) begin
          grant_o[o]      = '0;
          grant_o[o][idx] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_ports_lp; i++) begin
      for (int o = 0; o < num_ports_lp; o++) begin
        grant_by_in[i][o] = grant_o[o][i];
      end
      pop_o[i] = |grant_by_in[i];
    end
  end

  // Pointer steps past the winner
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int o = 0; o < num_ports_lp; o++) begin
        ptr_r[o] <= '0;
      end
    end else begin
      for (int o = 0; o < num_ports_lp; o++) begin
        for (int i = 0; i < num_ports_lp; i++) begin
          if (grant_o[o][i]) begin
            ptr_r[o] <= (i == num_ports_lp - 1) ? 3'd0 : 3'(i + 1);
          end
        end
      end
    end
  end

  for (genvar p = 0; p < num_ports_lp; p++) begin : g_chk
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grant_o[p]));
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grant_by_in[p]));
  end

endmodule

// File: design/tile_pkg.sv
package tile_pkg;

  typedef logic [3:0] round_t;

  // Wrapping sum of received payloads
  typedef logic [15:0] checksum_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT,
    DONE
  } tile_state_e;

endpackage

// File: design/traffic_tile.sv
`timescale 1ns/100ps

module traffic_tile
  import noc_pkg::*;
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  coord_t    my_x_i,
  input  coord_t    my_y_i,
  input  logic      start_i,
  input  round_t    rounds_i,
  input  logic      stall_i,
  output logic      inj_valid_o,
  output packet_t   inj_packet_o,
  input  logic      inj_ready_i,
  input  logic      ej_valid_i,
  input  packet_t   ej_packet_i,
  output logic      ej_ready_o,
  output checksum_t checksum_o,
  output logic      done_o,
  output logic      misroute_o
);

  tile_state_e state_r;
  round_t      rounds_r;
  round_t      round_r;
  coord_t      dest_x_r;
  coord_t      dest_y_r;
  logic [5:0]  recv_cnt_r;
  checksum_t   checksum_r;
  logic        misroute_r;
  node_id_t    my_id;
  logic [5:0]  expected;
  logic        inj_fire;
  logic        ej_fire;
  logic        last_dest;

  assign my_id    = node_id_t'(my_x_i + mesh_x_lp * my_y_i);
  assign expected = 6'(num_nodes_lp * rounds_r);

  // Sender
  assign inj_valid_o  = (state_r == SEND);
  assign inj_packet_o = pkt_make(dest_x_r, dest_y_r, {round_r, 4'(my_id)});
  assign inj_fire     = inj_valid_o & inj_ready_i;
  assign last_dest    = (dest_x_r == coord_t'(mesh_x_lp - 1)) &&
                        (dest_y_r == coord_t'(mesh_y_lp - 1));

  // Receiver
  assign ej_ready_o = ~stall_i;
  assign ej_fire    = ej_valid_i & ej_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= IDLE;
      rounds_r   <= '0;
      round_r    <= '0;
      dest_x_r   <= '0;
      dest_y_r   <= '0;
      recv_cnt_r <= '0;
      checksum_r <= '0;
      misroute_r <= 1'b0;
    end else begin
      if (ej_fire) begin
        checksum_r <= checksum_r + checksum_t'(pkt_payload(ej_packet_i));
        recv_cnt_r <= recv_cnt_r + 6'd1;
        if (pkt_x(ej_packet_i) != my_x_i || pkt_y(ej_packet_i) != my_y_i) begin
          misroute_r <= 1'b1;
        end
      end
      case (state_r)
        IDLE, DONE: begin
          // Start wins over any arrival on the same edge
          if (start_i) begin
            state_r    <= (rounds_i == '0) ? WAIT : SEND;
            rounds_r   <= rounds_i;
            round_r    <= '0;
            dest_x_r   <= '0;
            dest_y_r   <= '0;
            recv_cnt_r <= '0;
            checksum_r <= '0;
          end
        end
        SEND: begin
          if (inj_fire) begin
            if (dest_x_r == coord_t'(mesh_x_lp - 1)) begin
              dest_x_r <= '0;
              dest_y_r <= (dest_y_r == coord_t'(mesh_y_lp - 1)) ? '0 : dest_y_r + 1'b1;
            end else begin
              dest_x_r <= dest_x_r + 1'b1;
            end
            if (last_dest) begin
              round_r <= round_r + 1'b1;
              if (round_r == rounds_r - round_t'(1)) begin
                state_r <= WAIT;
              end
            end
          end
        end
        WAIT: begin
          if (recv_cnt_r == expected) begin
            state_r <= DONE;
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  assign checksum_o = checksum_r;
  assign done_o     = (state_r == DONE);
  assign misroute_o = misroute_r;

  // Injection follows the link handshake
  assert property (@(posedge clk_i) disable iff (reset_i)
    inj_valid_o && !inj_ready_i |=> inj_valid_o && $stable(inj_packet_o));

endmodule

// File: filelist.f
design/noc_pkg.sv
design/tile_pkg.sv
design/link_fifo.sv
design/route_ctrl.sv
design/mesh_router.sv
design/traffic_tile.sv
design/mesh_top.sv
tb/clk_gen.sv
tb/tb_mesh.sv

// File: tb/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
  output logic clk_o
);

  // 8 ns period
  localparam int half_period_lp = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #half_period_lp clk_o = ~clk_o;
    end
  end

endmodule

// File: tb/tb_mesh.sv
`timescale 1ns/100ps

module tb_mesh
  import noc_pkg::*;
  import tile_pkg::*;
;

  typedef enum logic [1:0] {STALL_NONE, STALL_FIXED, STALL_RANDOM} stall_mode_e;

  // One test row: stimulus and expected checksum per tile
  typedef struct packed {
    round_t                       rounds;
    stall_mode_e                  mode;
    logic [num_nodes_lp-1:0]      mask;
    logic [7:0]                   hold;
    checksum_t [num_nodes_lp-1:0] exp_sum;
  } row_t;

  localparam int num_rows_lp = 7;

  logic                         clk;
  logic                         reset;
  logic                         start;
  round_t                       rounds;
  logic      [num_nodes_lp-1:0] stall;
  logic                         done;
  checksum_t [num_nodes_lp-1:0] checksum;
  logic                         misroute;

  row_t rows [num_rows_lp];
  bit   table_ready = 1'b0;

  clk_gen clock (
    .clk_o(clk)
  );

  mesh_top uut (
    .clk_i     (clk),
    .reset_i   (reset),
    .start_i   (start),
    .rounds_i  (rounds),
    .stall_i   (stall),
    .done_o    (done),
    .checksum_o(checksum),
    .misroute_o(misroute)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Every source s sends 16*r + s to each node in round r
  function automatic checksum_t expected_checksum(round_t n_rounds);
    checksum_t sum;
    sum = '0;
    for (int r = 0; r < int'(n_rounds); r++) begin
      for (int s = 0; s < num_nodes_lp; s++) begin
        sum = sum + checksum_t'(16 * r + s);
      end
    end
    return sum;
  endfunction

  function automatic row_t make_row(round_t n_rounds, stall_mode_e mode,
                                    logic [num_nodes_lp-1:0] mask, logic [7:0] hold);
    row_t row;
    row.rounds = n_rounds;
    row.mode   = mode;
    row.mask   = mask;
    row.hold   = hold;
    for (int n = 0; n < num_nodes_lp; n++) begin
      row.exp_sum[n] = expected_checksum(n_rounds);
    end
    return row;
  endfunction

  task automatic fill_table();
    rows[0] = make_row(4'd1, STALL_NONE, 4'h0, 8'd0);
    rows[1] = make_row(4'd2, STALL_NONE, 4'h0, 8'd0);
    rows[2] = make_row(4'd4, STALL_NONE, 4'h0, 8'd0);
    rows[3] = make_row(4'd2, STALL_FIXED, 4'b0101, 8'd60);
    // All ejection stalled, back-pressure reaches the senders
    rows[4] = make_row(4'd3, STALL_FIXED, 4'b1111, 8'd40);
    rows[5] = make_row(4'd4, STALL_RANDOM, 4'h0, 8'd0);
    rows[6] = make_row(4'd2, STALL_RANDOM, 4'h0, 8'd0);
  endtask

  function automatic logic [num_nodes_lp-1:0] stall_value(row_t row, int cyc);
    logic [num_nodes_lp-1:0] value;
    case (row.mode)
      STALL_FIXED:  value = (cyc < int'(row.hold)) ? row.mask : '0;
      STALL_RANDOM: value = num_nodes_lp'($urandom);
      default:      value = '0;
    endcase
    return value;
  endfunction

  task automatic check_cleared(input string when);
    assert (done == 1'b0)
      else report_fail($sformatf("Fail done_o %s: got %h expected %h", when, done, 1'b0));
    assert (misroute == 1'b0)
      else report_fail($sformatf("Fail misroute_o %s: got %h expected %h", when, misroute, 1'b0));
    for (int n = 0; n < num_nodes_lp; n++) begin
      assert (checksum[n] == '0)
        else report_fail($sformatf("Fail checksum_o[%0d] %s: got %h expected %h",
                                   n, when, checksum[n], 16'h0));
    end
  endtask

  task automatic run_row(input int idx);
    row_t row;
    int   cyc;
    row = rows[idx];
    @(negedge clk);
    start  = 1'b1;
    rounds = row.rounds;
    stall  = '0;
    @(negedge clk);
    start = 1'b0;
    check_cleared($sformatf("after start of row %0d", idx));
    cyc = 0;
    while (done !== 1'b1) begin
      stall = stall_value(row, cyc);
      cyc++;
      @(negedge clk);
      assert (misroute == 1'b0)
        else report_fail($sformatf("Fail misroute_o in row %0d: got %h expected %h",
                                   idx, misroute, 1'b0));
    end
    stall = '0;
    for (int n = 0; n < num_nodes_lp; n++) begin
      assert (checksum[n] == row.exp_sum[n])
        else report_fail($sformatf("Fail checksum_o[%0d] in row %0d: got %h expected %h",
                                   n, idx, checksum[n], row.exp_sum[n]));
    end
    // Done holds until the next start
    repeat (4) begin
      @(negedge clk);
      assert (done == 1'b1)
        else report_fail($sformatf("Fail done_o held in row %0d: got %h expected %h",
                                   idx, done, 1'b1));
    end
  endtask

  initial begin : main
    void'($urandom(41));
    reset  = 1'b1;
    start  = 1'b0;
    rounds = '0;
    stall  = '0;
    fill_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_cleared("after reset");
    for (int i = 0; i < num_rows_lp; i++) begin
      run_row(i);
    end
    $display("TB PASSED");
    $finish;
  end

  // 400 cycles per round plus margin for reset and hold checks
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 20 + 10 * num_rows_lp;
    for (int i = 0; i < num_rows_lp; i++) begin
      limit = limit + 400 * int'(rows[i].rounds);
    end
    repeat (limit) @(posedge clk);
    report_fail($sformatf("Timeout: done_o not reached within %0d cycles", limit));
  end

endmodule
